/* tb.f */
+incdir+tb
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
tb/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* tb/rv_iss.svh */
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

// Architectural state of the reference model
logic [31:0] ref_regs [32];
logic [31:0] ref_pc;
logic [31:0] ref_mem [256]; // 1 KB data region at address zero

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return {31'b0, $signed(a) < $signed(b)};
    3'b011:  return {31'b0, a < b};
    3'b100:  return a ^ b;
    3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    3'b111:  return a >= b;
    default: return 1'b0;
  endcase
endfunction

// Retires one instruction, returns the next pc and any store it makes
function automatic logic [31:0] iss_step(input logic [31:0] ins, output logic st,
                                         output logic [31:0] st_addr,
                                         output logic [3:0] st_mask,
                                         output logic [31:0] st_data);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] ea;
  logic [31:0] word;
  logic [31:0] res;
  logic [31:0] next;
  logic [2:0]  f3;
  logic        wr;
  a     = ref_regs[ins[19:15]];
  b     = ref_regs[ins[24:20]];
  f3    = ins[14:12];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
  imm_u = {ins[31:12], 12'b0};
  imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
  next = ref_pc + 32'd4;
  wr = 1'b1;
  res = '0;
  st = 1'b0;
  st_addr = '0;
  st_mask = '0;
  st_data = '0;
  case (ins[6:0])
    opc_lui:    res = imm_u;
    opc_auipc:  res = ref_pc + imm_u;
    opc_jal: begin
      res  = ref_pc + 32'd4;
      next = ref_pc + imm_j;
    end
    opc_jalr: begin
      res  = ref_pc + 32'd4;
      next = (a + imm_i) & ~32'd1;
    end
    opc_branch: begin
      wr = 1'b0;
      if (branch_taken(f3, a, b)) next = ref_pc + imm_b;
    end
    opc_load: begin
      ea   = a + imm_i;
      word = ref_mem[ea[9:2]] >> {ea[1:0], 3'b000};
      case (f3)
        3'b000:  res = {{24{word[7]}}, word[7:0]};
        3'b001:  res = {{16{word[15]}}, word[15:0]};
        3'b100:  res = {24'b0, word[7:0]};
        3'b101:  res = {16'b0, word[15:0]};
        default: res = word;
      endcase
    end
    opc_store: begin
      wr      = 1'b0;
      ea      = a + imm_s;
      st      = 1'b1;
      st_addr = {ea[31:2], 2'b00};
      st_mask = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
      st_mask = st_mask << ea[1:0];
      st_data = b << {ea[1:0], 3'b000};
      for (int i = 0; i < 4; i++) begin
        if (st_mask[i]) ref_mem[ea[9:2]][8*i +: 8] = st_data[8*i +: 8];
      end
    end
    opc_op_imm: res = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
    opc_op:     res = alu_ref(f3, ins[30], a, b);
    default:    wr = 1'b0; // No-op
  endcase
  if (wr && ins[11:7] != 5'd0) ref_regs[ins[11:7]] = res;
  ref_pc = next;
  return next;
endfunction

`endif

/* tb/tb_rv_core.sv */
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam logic [31:0] self_jump = 32'h0000_006f;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        dmem_en;
  logic        dmem_we;
  logic [31:0] dmem_addr;
  logic [3:0]  dmem_wmask;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;

  logic [31:0] imem [512];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  logic [31:0] seed = 32'ha8b6;
  logic        done = 1'b0;
  logic        prev_rst = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cycles = 0;
  int          cycle_limit = 200;
  int          st_off = 0;

  `include "rv_iss.svh"

  rv_core u_rv_core (
    .clk(clk), .rst(rst), .pc(pc), .instr(instr), .dmem_en(dmem_en), .dmem_we(dmem_we),
    .dmem_addr(dmem_addr), .dmem_wmask(dmem_wmask), .dmem_wdata(dmem_wdata),
    .dmem_rdata(dmem_rdata)
  );

  always #5 clk = ~clk;

  assign instr      = imem[9'((pc - reset_vector) >> 2)];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_wmask[i]) dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
      end
    end
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] byte_bits(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  function automatic logic [31:0] r_word(input int f3, input int f7, input int rd,
                                         input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_op};
  endfunction

  function automatic logic [31:0] i_word(input opcode_e opc, input int f3, input int rd,
                                         input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] s_word(input int f3, input int rs1, input int rs2,
                                         input int off);
    return {off[11:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:0], opc_store};
  endfunction

  function automatic logic [31:0] b_word(input int f3, input int rs1, input int rs2,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] u_word(input opcode_e opc, input int rd, input int hi);
    return {hi[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] j_word(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
  endfunction

  task automatic store_reg(input int r);
    prog.push_back(s_word(2, 0, r, st_off));
    st_off = (st_off + 4) % 1024;
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // Reset checks, then the pc and data port against the model
  always @(posedge clk) begin
    logic        st;
    logic [31:0] sa;
    logic [31:0] sd;
    logic [31:0] next;
    logic [31:0] ins;
    logic [3:0]  sm;
    if (rst) begin
      checks++;
      assert (!dmem_en && !dmem_we) else report_mismatch("data port active in reset");
      if (prev_rst) begin
        assert (pc == reset_vector)
        else report_mismatch($sformatf("reset pc %h", pc));
      end
    end else if (!done) begin
      checks++;
      assert (pc == ref_pc)
      else report_mismatch($sformatf("pc %h, expected %h", pc, ref_pc));
      ins  = imem[9'((ref_pc - reset_vector) >> 2)];
      next = iss_step(ins, st, sa, sm, sd);
      assert (dmem_we == st)
      else report_mismatch($sformatf("dmem_we %b at pc %h", dmem_we, pc));
      assert (dmem_en == (st || ins[6:0] == opc_load))
      else report_mismatch($sformatf("dmem_en %b at pc %h", dmem_en, pc));
      if (st) begin
        assert (dmem_addr == sa && dmem_wmask == sm)
        else report_mismatch($sformatf("store %h/%b, expected %h/%b",
                                       dmem_addr, dmem_wmask, sa, sm));
        assert ((dmem_wdata & byte_bits(sm)) == (sd & byte_bits(sm)))
        else report_mismatch($sformatf("store data %h, expected %h", dmem_wdata, sd));
      end
      if (ins == self_jump) done <= 1'b1; // End of program
    end
    prev_rst <= rst;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic run_test(input string name);
    int errs_before;
    errs_before = errors;
    prog.push_back(self_jump);
    cycle_limit += prog.size() + 16;
    rst <= 1'b1;
    @(posedge clk);
    foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
    ref_pc = reset_vector;
    done <= 1'b0;
    repeat (15) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    while (!done) @(posedge clk);
    $display("[%s] %0d instructions, %0d mismatches", name, prog.size(),
             errors - errs_before);
    tests++;
    prog.delete();
  endtask

  initial begin
    int pairs [5][2];
    int imms [4];
    int shamts [3];
    int ld_f3 [4];
    int br_f3 [6];
    int br_rs2 [3];
    rst = 1'b1;
    pairs  = '{'{1, 2}, '{2, 3}, '{4, 5}, '{3, 6}, '{2, 1}};
    imms   = '{-1, 7, -2048, 1};
    shamts = '{0, 31, 5};
    ld_f3  = '{0, 4, 1, 5};
    br_f3  = '{0, 1, 4, 5, 6, 7};
    br_rs2 = '{3, 2, 1};
    foreach (ref_regs[i]) ref_regs[i] = '0;
    for (int i = 0; i < 256; i++) begin
      dmem[i]    = (i * 4) * 32'h9e37_79b1 ^ 32'h5ac3_c35a; // Fill from byte address
      ref_mem[i] = dmem[i];
    end

    for (int r = 1; r < 32; r++) prog.push_back(i_word(opc_op_imm, 0, r, 0, 0));
    prog.push_back(i_word(opc_op_imm, 0, 1, 0, 5));
    store_reg(1);
    run_test("reset");

    prog.push_back(u_word(opc_lui, 1, 'h80000));
    prog.push_back(i_word(opc_op_imm, 0, 2, 0, -1));
    prog.push_back(i_word(opc_op_imm, 0, 3, 0, 7));
    prog.push_back(u_word(opc_lui, 4, 'h12345));
    prog.push_back(i_word(opc_op_imm, 0, 4, 4, 'h678));
    prog.push_back(i_word(opc_op_imm, 0, 5, 0, 31));
    prog.push_back(i_word(opc_op_imm, 0, 6, 0, 0));
    for (int p = 0; p < 5; p++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        prog.push_back(r_word(f3, 0, 10, pairs[p][0], pairs[p][1]));
        store_reg(10);
        if (f3 == 0 || f3 == 5) begin
          prog.push_back(r_word(f3, 'h20, 10, pairs[p][0], pairs[p][1]));
          store_reg(10);
        end
      end
    end
    for (int p = 0; p < 3; p++) begin
      foreach (imms[k]) begin
        for (int f3 = 0; f3 < 8; f3++) begin
          if (f3 != 1 && f3 != 5) begin
            prog.push_back(i_word(opc_op_imm, f3, 10, pairs[p][0] + p, imms[k]));
            store_reg(10);
          end
        end
      end
      foreach (shamts[k]) begin
        prog.push_back(i_word(opc_op_imm, 1, 10, 4 - p, shamts[k]));
        store_reg(10);
        prog.push_back(i_word(opc_op_imm, 5, 10, 4 - p, shamts[k]));
        store_reg(10);
        prog.push_back(i_word(opc_op_imm, 5, 10, 4 - p, 'h400 | shamts[k]));
        store_reg(10);
      end
    end
    prog.push_back(r_word(0, 0, 0, 4, 3)); // Write to x0 is dropped
    store_reg(0);
    run_test("alu");

    prog.push_back(u_word(opc_lui, 7, 'h8badf));
    prog.push_back(i_word(opc_op_imm, 0, 7, 7, 'h00d));
    for (int off = 0; off < 4; off++) begin
      prog.push_back(s_word(0, 0, 7, 256 + off));
      if (off % 2 == 0) prog.push_back(s_word(1, 0, 7, 272 + off));
    end
    prog.push_back(s_word(2, 0, 7, 288));
    for (int off = 0; off < 4; off++) begin
      foreach (ld_f3[k]) begin
        if (ld_f3[k] % 4 == 0 || off % 2 == 0) begin
          prog.push_back(i_word(opc_load, ld_f3[k], 8, 0, 288 + off));
          store_reg(8);
        end
      end
    end
    prog.push_back(i_word(opc_load, 2, 8, 0, 288));
    store_reg(8);
    prog.push_back(i_word(opc_load, 1, 8, 0, 1018)); // Fill pattern region
    store_reg(8);
    run_test("ldst");

    prog.push_back(i_word(opc_op_imm, 0, 1, 0, 5));
    prog.push_back(i_word(opc_op_imm, 0, 2, 0, -3));
    prog.push_back(i_word(opc_op_imm, 0, 3, 0, 5));
    foreach (br_f3[k]) begin
      for (int p = 0; p < 3; p++) begin
        prog.push_back(b_word(br_f3[k], p == 2 ? 2 : 1, br_rs2[p], 8));
        prog.push_back(i_word(opc_op_imm, 0, 9, 9, 1)); // Skipped when taken
        store_reg(9);
      end
    end
    prog.push_back(i_word(opc_op_imm, 0, 11, 0, 3));
    prog.push_back(i_word(opc_op_imm, 0, 11, 11, -1));
    store_reg(11);
    prog.push_back(b_word(1, 11, 0, -8));
    prog.push_back(i_word(opc_op_imm, 0, 12, 0, 2));
    prog.push_back(i_word(opc_op_imm, 0, 12, 12, -1));
    prog.push_back(b_word(5, 12, 0, -4));
    prog.push_back(j_word(13, 8));
    prog.push_back(i_word(opc_op_imm, 0, 9, 9, 1));
    store_reg(13);
    prog.push_back(u_word(opc_auipc, 14, 0));
    prog.push_back(i_word(opc_jalr, 0, 15, 14, 13)); // Bit 0 of the target cleared
    prog.push_back(i_word(opc_op_imm, 0, 9, 9, 1));
    store_reg(15);
    store_reg(9);
    run_test("branch");

    for (int n = 0; n < 200; n++) begin
      logic [31:0] r;
      int f3;
      r  = lcg_next();
      f3 = int'(r[14:12]);
      if (r[0]) begin
        prog.push_back(r_word(f3, (f3 == 0 || f3 == 5) && r[1] ? 'h20 : 0,
                              int'(r[11:7]), int'(r[19:15]), int'(r[24:20])));
      end else if (f3 == 1 || f3 == 5) begin
        prog.push_back(i_word(opc_op_imm, f3, int'(r[11:7]), int'(r[19:15]),
                              (f3 == 5 && r[1]) ? 'h400 | int'(r[24:20]) : int'(r[24:20])));
      end else begin
        prog.push_back(i_word(opc_op_imm, f3, int'(r[11:7]), int'(r[19:15]),
                              int'(r[31:20])));
      end
      if (n % 4 == 3) begin
        r = lcg_next();
        prog.push_back(s_word(2, 0, int'(r[4:0]), int'({r[15:8], 2'b00})));
      end
    end
    run_test("random");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog/rv_core.sv */
module rv_core (
  input  logic                         clk,
  input  logic                         rst,
  output logic [rv_core_pkg::xlen-1:0] pc,
  input  logic [31:0]                  instr,
  output logic                         dmem_en,
  output logic                         dmem_we,
  output logic [31:0]                  dmem_addr,
  output logic [3:0]                   dmem_wmask,
  output logic [31:0]                  dmem_wdata,
  input  logic [31:0]                  dmem_rdata
);
  import rv_core_pkg::*;

  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [xlen-1:0] imm;
  alu_op_e         alu_op;
  cmp_op_e         cmp_op;
  logic            a_is_pc;
  logic            b_is_imm;
  logic            reg_we;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            mem_read;
  logic            mem_write;
  logic            mem_unsigned;
  mem_size_e       mem_size;
  wb_sel_e         wb_sel;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic            cmp_true;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_target;
  logic [xlen-1:0] pc_next;

  rv_decoder u_decoder (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .cmp_op(cmp_op), .a_is_pc(a_is_pc), .b_is_imm(b_is_imm),
    .reg_we(reg_we), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .mem_read(mem_read), .mem_write(mem_write), .mem_unsigned(mem_unsigned),
    .mem_size(mem_size), .wb_sel(wb_sel)
  );

  rv_regfile u_regfile (
    .clk(clk), .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data),
    .waddr(rd), .wdata(wb_data), .we(reg_we & ~rst)
  );

  assign op_a = a_is_pc ? pc : rs1_data;
  assign op_b = b_is_imm ? imm : rs2_data;

  rv_alu u_alu (
    .op_a(op_a), .op_b(op_b), .alu_op(alu_op), .cmp_op(cmp_op),
    .result(alu_result), .cmp_true(cmp_true)
  );

  rv_lsu u_lsu (
    .addr(alu_result), .store_data(rs2_data),
    .mem_read(mem_read & ~rst), .mem_write(mem_write & ~rst),
    .mem_unsigned(mem_unsigned), .mem_size(mem_size),
    .dmem_en(dmem_en), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
    .dmem_wmask(dmem_wmask), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
    .load_data(load_data)
  );

  always_comb begin
    case (wb_sel)
      wb_load:     wb_data = load_data;
      wb_pc_plus4: wb_data = pc_plus4; // Link value
      default:     wb_data = alu_result;
    endcase
  end

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm; // JAL and taken branches

  always_comb begin
    if (is_jalr) pc_next = {alu_result[xlen-1:1], 1'b0};
    else if (is_jal || (is_branch && cmp_true)) pc_next = pc_target;
    else pc_next = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_vector;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

/* verilog/rv_lsu.sv */
module rv_lsu (
  input  logic [rv_core_pkg::xlen-1:0] addr,
  input  logic [rv_core_pkg::xlen-1:0] store_data,
  input  logic                         mem_read,
  input  logic                         mem_write,
  input  logic                         mem_unsigned,
  input  rv_core_pkg::mem_size_e       mem_size,
  output logic                         dmem_en,
  output logic                         dmem_we,
  output logic [31:0]                  dmem_addr,
  output logic [3:0]                   dmem_wmask,
  output logic [31:0]                  dmem_wdata,
  input  logic [31:0]                  dmem_rdata,
  output logic [31:0]                  load_data
);
  import rv_core_pkg::*;

  logic [1:0]      offset;
  logic [3:0]      size_mask;
  logic [xlen-1:0] lane_data;

  assign offset    = addr[1:0];
  assign dmem_en   = mem_read | mem_write;
  assign dmem_we   = mem_write;
  assign dmem_addr = {addr[xlen-1:2], 2'b00}; // Word aligned

  always_comb begin
    case (mem_size)
      mem_byte: size_mask = 4'b0001;
      mem_half: size_mask = 4'b0011;
      default:  size_mask = 4'b1111;
    endcase
  end

  assign dmem_wmask = mem_write ? (size_mask << offset) : 4'b0000;
  assign dmem_wdata = store_data << {offset, 3'b000}; // Into byte lanes

  // Addressed byte or half moved down to bit 0
  assign lane_data = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (mem_size)
      mem_byte: begin
        if (mem_unsigned) load_data = {24'b0, lane_data[7:0]};
        else load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      end
      mem_half: begin
        if (mem_unsigned) load_data = {16'b0, lane_data[15:0]};
        else load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      end
      default: load_data = dmem_rdata;
    endcase
  end

endmodule

/* verilog/rv_regfile.sv */
module rv_regfile (
  input  logic                         clk,
  input  logic [4:0]                   raddr1,
  input  logic [4:0]                   raddr2,
  output logic [rv_core_pkg::xlen-1:0] rdata1,
  output logic [rv_core_pkg::xlen-1:0] rdata2,
  input  logic [4:0]                   waddr,
  input  logic [rv_core_pkg::xlen-1:0] wdata,
  input  logic                         we
);
  import rv_core_pkg::*;

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* verilog/rv_alu.sv */
module rv_alu (
  input  logic [rv_core_pkg::xlen-1:0] op_a,
  input  logic [rv_core_pkg::xlen-1:0] op_b,
  input  rv_core_pkg::alu_op_e         alu_op,
  input  rv_core_pkg::cmp_op_e         cmp_op,
  output logic [rv_core_pkg::xlen-1:0] result,
  output logic                         cmp_true
);
  import rv_core_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = op_b[4:0];
  assign eq    = (op_a == op_b);
  assign lt_s  = ($signed(op_a) < $signed(op_b));
  assign lt_u  = (op_a < op_b);

  always_comb begin
    case (alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = op_a - op_b;
      alu_sll:  result = op_a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  result = op_a ^ op_b;
      alu_srl:  result = op_a >> shamt;
      alu_sra:  result = $signed(op_a) >>> shamt;
      alu_or:   result = op_a | op_b;
      alu_and:  result = op_a & op_b;
      default:  result = op_b; // PASS_B for LUI
    endcase
  end

  // Branch outcome on the same operands
  always_comb begin
    case (cmp_op)
      cmp_eq:  cmp_true = eq;
      cmp_ne:  cmp_true = !eq;
      cmp_lt:  cmp_true = lt_s;
      cmp_ge:  cmp_true = !lt_s;
      cmp_ltu: cmp_true = lt_u;
      cmp_geu: cmp_true = !lt_u;
      default: cmp_true = 1'b0;
    endcase
  end

endmodule

/* verilog/rv_decoder.sv */
module rv_decoder (
  input  logic [31:0]                  instr,
  output logic [4:0]                   rs1,
  output logic [4:0]                   rs2,
  output logic [4:0]                   rd,
  output logic [rv_core_pkg::xlen-1:0] imm,
  output rv_core_pkg::alu_op_e         alu_op,
  output rv_core_pkg::cmp_op_e         cmp_op,
  output logic                         a_is_pc,
  output logic                         b_is_imm,
  output logic                         reg_we,
  output logic                         is_branch,
  output logic                         is_jal,
  output logic                         is_jalr,
  output logic                         mem_read,
  output logic                         mem_write,
  output logic                         mem_unsigned,
  output rv_core_pkg::mem_size_e       mem_size,
  output rv_core_pkg::wb_sel_e         wb_sel
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;
  logic       rd_write;
  imm_fmt_e   fmt;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign reg_we = rd_write && (rd != 5'd0); // x0 never written

  always_comb begin
    legal        = 1'b1;
    rd_write     = 1'b0;
    fmt          = imm_none;
    alu_op       = alu_add;
    cmp_op       = cmp_eq;
    a_is_pc      = 1'b0;
    b_is_imm     = 1'b0;
    is_branch    = 1'b0;
    is_jal       = 1'b0;
    is_jalr      = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    mem_unsigned = 1'b0;
    mem_size     = mem_word;
    wb_sel       = wb_alu;
    case (opcode)
      opc_lui: begin
        rd_write = 1'b1;
        fmt      = imm_u;
        b_is_imm = 1'b1;
        alu_op   = alu_pass_b;
      end
      opc_auipc: begin
        rd_write = 1'b1;
        fmt      = imm_u;
        a_is_pc  = 1'b1;
        b_is_imm = 1'b1;
      end
      opc_jal: begin
        rd_write = 1'b1;
        fmt      = imm_j;
        is_jal   = 1'b1;
        wb_sel   = wb_pc_plus4;
      end
      opc_jalr: begin
        rd_write = 1'b1;
        fmt      = imm_i;
        b_is_imm = 1'b1; // Target from the ALU sum
        is_jalr  = 1'b1;
        wb_sel   = wb_pc_plus4;
        legal    = (funct3 == 3'b000);
      end
      opc_branch: begin
        fmt       = imm_b;
        is_branch = 1'b1;
        case (funct3)
          f3_beq:  cmp_op = cmp_eq;
          f3_bne:  cmp_op = cmp_ne;
          f3_blt:  cmp_op = cmp_lt;
          f3_bge:  cmp_op = cmp_ge;
          f3_bltu: cmp_op = cmp_ltu;
          f3_bgeu: cmp_op = cmp_geu;
          default: legal = 1'b0;
        endcase
      end
      opc_load: begin
        rd_write     = 1'b1;
        fmt          = imm_i;
        b_is_imm     = 1'b1;
        mem_read     = 1'b1;
        wb_sel       = wb_load;
        mem_size     = mem_size_e'(funct3[1:0]);
        mem_unsigned = funct3[2];
        legal = (funct3 == f3_lb) || (funct3 == f3_lh) || (funct3 == f3_lw) ||
                (funct3 == f3_lbu) || (funct3 == f3_lhu);
      end
      opc_store: begin
        fmt       = imm_s;
        b_is_imm  = 1'b1;
        mem_write = 1'b1;
        mem_size  = mem_size_e'(funct3[1:0]);
        legal = (funct3 == f3_sb) || (funct3 == f3_sh) || (funct3 == f3_sw);
      end
      opc_op_imm, opc_op: begin
        rd_write = 1'b1;
        if (opcode == opc_op_imm) begin
          fmt      = imm_i;
          b_is_imm = 1'b1;
        end
        case (funct3)
          f3_add: begin
            if (opcode == opc_op && funct7 == funct7_alt) alu_op = alu_sub;
            else alu_op = alu_add;
          end
          f3_sll:  alu_op = alu_sll;
          f3_slt:  alu_op = alu_slt;
          f3_sltu: alu_op = alu_sltu;
          f3_xor:  alu_op = alu_xor;
          f3_srl: begin
            if (funct7 == funct7_alt) alu_op = alu_sra;
            else alu_op = alu_srl;
          end
          f3_or:   alu_op = alu_or;
          f3_and:  alu_op = alu_and;
        endcase
        // funct7 is part of the immediate except for shifts
        if (opcode == opc_op || funct3 == f3_sll || funct3 == f3_srl) begin
          legal = (funct7 == funct7_base) ||
                  (funct7 == funct7_alt && (funct3 == f3_srl ||
                   (funct3 == f3_add && opcode == opc_op)));
        end
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin // Executes as a no-op
      rd_write  = 1'b0;
      is_branch = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
    end
  end

  always_comb begin
    case (fmt)
      imm_i:   imm = {{20{instr[31]}}, instr[31:20]};
      imm_s:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      imm_u:   imm = {instr[31:12], 12'b0};
      imm_j:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

/* verilog/rv_core_pkg.sv */
package rv_core_pkg;

  localparam int xlen = 32;

  localparam logic [31:0] reset_vector = 32'h8000_0000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b // LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    cmp_eq,
    cmp_ne,
    cmp_lt,
    cmp_ge,
    cmp_ltu,
    cmp_geu
  } cmp_op_e;

  // Same order as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    mem_byte = 2'b00,
    mem_half = 2'b01,
    mem_word = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_pc_plus4
  } wb_sel_e;

endpackage

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lh  = 3'b001;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_lhu = 3'b101;

  localparam logic [2:0] f3_sb = 3'b000;
  localparam logic [2:0] f3_sh = 3'b001;
  localparam logic [2:0] f3_sw = 3'b010;

  localparam logic [2:0] f3_add  = 3'b000; // Also SUB and ADDI
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101; // Also SRA
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000; // SUB, SRA, SRAI

  typedef enum logic [2:0] {
    imm_none,
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_fmt_e;

endpackage
